/* source/seg_pkg.sv */
package seg_pkg;

    // ------------------------------------------------------------------
    // Frame geometry
    // ------------------------------------------------------------------
    localparam int FRAME_WIDTH  = 16;
    localparam int FRAME_HEIGHT = 8;
    localparam int H_W          = $clog2(FRAME_WIDTH);
    localparam int V_W          = $clog2(FRAME_HEIGHT);

    // One pooled column per horizontal pair
    localparam int POOL_COLS = FRAME_WIDTH / 2;
    localparam int POOL_CW   = H_W - 1;

    // ------------------------------------------------------------------
    // Scores and pipeline depth
    // ------------------------------------------------------------------
    localparam int NUM_CLASSES = 4;
    localparam int SCORE_W     = 13;
    localparam int MERGE_W     = SCORE_W + 1;

    localparam int SKIP_DEPTH   = 2 * FRAME_WIDTH;
    localparam int SKIP_AW      = $clog2(SKIP_DEPTH);
    localparam int SKIP_FILL_W  = $clog2(SKIP_DEPTH + 1);
    localparam int PIPE_LATENCY = SKIP_DEPTH + 3;

    typedef logic signed [SCORE_W-1:0] score_t;
    typedef logic signed [MERGE_W-1:0] merge_t;

    typedef score_t [NUM_CLASSES-1:0] score_vec_t;
    typedef merge_t [NUM_CLASSES-1:0] merge_vec_t;

    typedef struct packed {
        logic [V_W-1:0] vcnt;
        logic [H_W-1:0] hcnt;
        score_vec_t     score;
    } pixel_t;

    typedef enum logic [1:0] {
        CLASS_0 = 2'd0,
        CLASS_1 = 2'd1,
        CLASS_2 = 2'd2,
        CLASS_3 = 2'd3
    } class_label_e;

endpackage

/* source/max_pool.sv */
`timescale 1ns/1ns

module max_pool (
    input  logic                        clock,
    input  logic                        rst_n,
    input  seg_pkg::pixel_t             in_pix,
    input  logic                        pool_rd_row,
    input  logic [seg_pkg::POOL_CW-1:0] pool_rd_col,
    output seg_pkg::score_vec_t         pool_rd_data
);

    import seg_pkg::*;

    // Left pixel of the current horizontal pair
    score_vec_t pair_hold;
    score_vec_t pair_max;

    // Pair maxima of the even row, waiting for the odd row
    score_vec_t line_max [POOL_COLS];

    // Pooled rows, banked by pooled row parity
    score_vec_t pool_bank [2][POOL_COLS];

    logic [POOL_CW-1:0] col;

    // Raster tracking for the step check
    logic [H_W-1:0] prev_hcnt;
    logic           prev_seen;

    function automatic score_vec_t vec_max(input score_vec_t a, input score_vec_t b);
        score_vec_t res;
        score_t     ca;
        score_t     cb;
        for (int c = 0; c < NUM_CLASSES; c++) begin
            ca = a[c];
            cb = b[c];
            res[c] = (ca > cb) ? ca : cb;
        end
        return res;
    endfunction

    assign col      = in_pix.hcnt[H_W-1:1];
    assign pair_max = vec_max(pair_hold, in_pix.score);

    // ------------------------------------------------------------------
    // Pooling
    // ------------------------------------------------------------------
    // Even column: hold the left pixel
    // Odd column, even row: park the pair maximum
    // Odd column, odd row: block maximum into the bank
    always_ff @(posedge clock) begin
        if (!in_pix.hcnt[0]) begin
            pair_hold <= in_pix.score;
        end else if (!in_pix.vcnt[0]) begin
            line_max[col] <= pair_max;
        end else begin
            pool_bank[in_pix.vcnt[1]][col] <= vec_max(line_max[col], pair_max);
        end
    end

    // Read side for the unpooling stage
    assign pool_rd_data = pool_bank[pool_rd_row][pool_rd_col];

    // ------------------------------------------------------------------
    // Raster check
    // ------------------------------------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            prev_hcnt <= '0;
            prev_seen <= 1'b0;
        end else begin
            prev_hcnt <= in_pix.hcnt;
            prev_seen <= 1'b1;
        end
    end

    // Pair and line phases rely on an unbroken pixel stream
    hcnt_step_a: assert property (
        @(posedge clock) disable iff (!rst_n)
        prev_seen |-> (in_pix.hcnt == ((prev_hcnt == H_W'(FRAME_WIDTH - 1)) ?
                                       H_W'(0) : H_W'(prev_hcnt + 1'b1)))
    );

endmodule

/* source/skip_line_delay.sv */
`timescale 1ns/1ns

module skip_line_delay (
    input  logic            clock,
    input  logic            rst_n,
    input  seg_pkg::pixel_t in_pix,
    output seg_pkg::pixel_t skip_pix,
    output logic            skip_valid
);

    import seg_pkg::*;

    // Two full lines of raw pixels
    pixel_t line_ram [SKIP_DEPTH];

    logic [SKIP_AW-1:0]     addr;
    logic [SKIP_FILL_W-1:0] fill_cnt;

    // ------------------------------------------------------------------
    // Circular buffer
    // ------------------------------------------------------------------
    // Slot is read out in the cycle it is overwritten
    assign skip_pix = line_ram[addr];

    always_ff @(posedge clock) begin
        line_ram[addr] <= in_pix;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            addr <= '0;
        end else if (addr == SKIP_AW'(SKIP_DEPTH - 1)) begin
            addr <= '0;
        end else begin
            addr <= addr + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Fill tracking
    // ------------------------------------------------------------------
    // Saturates once the buffer has wrapped
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt <= '0;
        end else if (!skip_valid) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    assign skip_valid = (fill_cnt == SKIP_FILL_W'(SKIP_DEPTH));

    // Stream stays valid until the next reset
    skip_valid_hold_a: assert property (
        @(posedge clock) disable iff (!rst_n)
        skip_valid |=> skip_valid
    );

endmodule

/* source/unpool_merge.sv */
`timescale 1ns/1ns

module unpool_merge (
    input  logic                        clock,
    input  logic                        rst_n,
    input  seg_pkg::pixel_t             skip_pix,
    input  logic                        skip_valid,
    output logic                        pool_rd_row,
    output logic [seg_pkg::POOL_CW-1:0] pool_rd_col,
    input  seg_pkg::score_vec_t         pool_rd_data,
    output seg_pkg::merge_vec_t         merged,
    output logic [seg_pkg::V_W-1:0]     merged_vcnt,
    output logic [seg_pkg::H_W-1:0]     merged_hcnt,
    output logic                        merged_valid
);

    import seg_pkg::*;

    merge_vec_t merge_next;

    // ------------------------------------------------------------------
    // Nearest-neighbour lookup
    // ------------------------------------------------------------------
    // Halved coordinates, row parity picks the bank
    assign pool_rd_row = skip_pix.vcnt[1];
    assign pool_rd_col = skip_pix.hcnt[H_W-1:1];

    // Sign extended per channel, one spare bit for the sum
    always_comb begin
        score_t skip_val;
        score_t pool_val;
        for (int c = 0; c < NUM_CLASSES; c++) begin
            skip_val      = skip_pix.score[c];
            pool_val      = pool_rd_data[c];
            merge_next[c] = merge_t'(skip_val) + merge_t'(pool_val);
        end
    end

    // ------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------
    always_ff @(posedge clock) begin
        merged      <= merge_next;
        merged_vcnt <= skip_pix.vcnt;
        merged_hcnt <= skip_pix.hcnt;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            merged_valid <= 1'b0;
        end else begin
            merged_valid <= skip_valid;
        end
    end

endmodule

/* source/class_argmax.sv */
`timescale 1ns/1ns

module class_argmax (
    input  logic                    clock,
    input  logic                    rst_n,
    input  seg_pkg::merge_vec_t     merged,
    input  logic [seg_pkg::V_W-1:0] merged_vcnt,
    input  logic [seg_pkg::H_W-1:0] merged_hcnt,
    input  logic                    merged_valid,
    output seg_pkg::class_label_e   out_label,
    output logic [seg_pkg::V_W-1:0] out_vcnt,
    output logic [seg_pkg::H_W-1:0] out_hcnt,
    output logic                    out_valid
);

    import seg_pkg::*;

    merge_t ch0;
    merge_t ch1;
    merge_t ch2;
    merge_t ch3;

    // Stage one results
    merge_t         max_lo;
    merge_t         max_hi;
    class_label_e   win_lo;
    class_label_e   win_hi;
    logic [V_W-1:0] vcnt_s1;
    logic [H_W-1:0] hcnt_s1;
    logic           valid_s1;

    assign ch0 = merged[0];
    assign ch1 = merged[1];
    assign ch2 = merged[2];
    assign ch3 = merged[3];

    // ------------------------------------------------------------------
    // Comparator tree
    // ------------------------------------------------------------------
    // Only a strictly greater score wins, so ties go upward
    always_ff @(posedge clock) begin
        if (ch0 > ch1) begin
            max_lo <= ch0;
            win_lo <= CLASS_0;
        end else begin
            max_lo <= ch1;
            win_lo <= CLASS_1;
        end
        if (ch2 > ch3) begin
            max_hi <= ch2;
            win_hi <= CLASS_2;
        end else begin
            max_hi <= ch3;
            win_hi <= CLASS_3;
        end
        vcnt_s1 <= merged_vcnt;
        hcnt_s1 <= merged_hcnt;

        out_label <= (max_lo > max_hi) ? win_lo : win_hi;
        out_vcnt  <= vcnt_s1;
        out_hcnt  <= hcnt_s1;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_s1  <= merged_valid;
            out_valid <= valid_s1;
        end
    end

endmodule

/* source/seg_top.sv */
`timescale 1ns/1ns

module seg_top (
    input  logic                    clock,
    input  logic                    rst_n,
    input  seg_pkg::score_vec_t     in_score,
    input  logic [seg_pkg::V_W-1:0] in_vcnt,
    input  logic [seg_pkg::H_W-1:0] in_hcnt,
    output seg_pkg::class_label_e   out_label,
    output logic [seg_pkg::V_W-1:0] out_vcnt,
    output logic [seg_pkg::H_W-1:0] out_hcnt,
    output logic                    out_valid
);

    import seg_pkg::*;

    pixel_t in_pix;
    pixel_t skip_pix;
    logic   skip_valid;

    logic               pool_rd_row;
    logic [POOL_CW-1:0] pool_rd_col;
    score_vec_t         pool_rd_data;

    merge_vec_t     merged;
    logic [V_W-1:0] merged_vcnt;
    logic [H_W-1:0] merged_hcnt;
    logic           merged_valid;

    assign in_pix = '{vcnt: in_vcnt, hcnt: in_hcnt, score: in_score};

    // ------------------------------------------------------------------
    // Encoder side and skip path
    // ------------------------------------------------------------------
    max_pool u_max_pool (
        .clock        (clock),
        .rst_n        (rst_n),
        .in_pix       (in_pix),
        .pool_rd_row  (pool_rd_row),
        .pool_rd_col  (pool_rd_col),
        .pool_rd_data (pool_rd_data)
    );

    skip_line_delay u_skip_line_delay (
        .clock      (clock),
        .rst_n      (rst_n),
        .in_pix     (in_pix),
        .skip_pix   (skip_pix),
        .skip_valid (skip_valid)
    );

    // ------------------------------------------------------------------
    // Decoder side and label
    // ------------------------------------------------------------------
    unpool_merge u_unpool_merge (
        .clock        (clock),
        .rst_n        (rst_n),
        .skip_pix     (skip_pix),
        .skip_valid   (skip_valid),
        .pool_rd_row  (pool_rd_row),
        .pool_rd_col  (pool_rd_col),
        .pool_rd_data (pool_rd_data),
        .merged       (merged),
        .merged_vcnt  (merged_vcnt),
        .merged_hcnt  (merged_hcnt),
        .merged_valid (merged_valid)
    );

    class_argmax u_class_argmax (
        .clock        (clock),
        .rst_n        (rst_n),
        .merged       (merged),
        .merged_vcnt  (merged_vcnt),
        .merged_hcnt  (merged_hcnt),
        .merged_valid (merged_valid),
        .out_label    (out_label),
        .out_vcnt     (out_vcnt),
        .out_hcnt     (out_hcnt),
        .out_valid    (out_valid)
    );

endmodule

/* tb/seg_model.svh */
`ifndef SEG_MODEL_SVH
`define SEG_MODEL_SVH

// ----------------------------------------------------------------------
// Galois LFSR, taps 16, 14, 13, 11
// ----------------------------------------------------------------------
// One step per bit taken, first bit ends up as the MSB of the value
function automatic int take_bits(input int count);
    int   value;
    logic out_bit;
    value = 0;
    for (int i = 0; i < count; i++) begin
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        value = (value << 1) | int'(out_bit);
    end
    return value;
endfunction

// ----------------------------------------------------------------------
// Reference model
// ----------------------------------------------------------------------
// A class wins only when strictly greater, so ties go to the higher class
function automatic int pick_label(input int m0, input int m1, input int m2, input int m3);
    int lo_max;
    int hi_max;
    int lo_win;
    int hi_win;
    lo_max = (m0 > m1) ? m0 : m1;
    lo_win = (m0 > m1) ? 0 : 1;
    hi_max = (m2 > m3) ? m2 : m3;
    hi_win = (m2 > m3) ? 2 : 3;
    return (lo_max > hi_max) ? lo_win : hi_win;
endfunction

// Block maximum of the 2x2 block holding (v, h), added to the pixel itself
function automatic void predict_frame();
    int pooled;
    int top;
    int left;
    int merged [NUM_CLASSES];
    for (int v = 0; v < FRAME_HEIGHT; v++) begin
        for (int h = 0; h < FRAME_WIDTH; h++) begin
            top  = v - (v % 2);
            left = h - (h % 2);
            for (int c = 0; c < NUM_CLASSES; c++) begin
                pooled = frame_score[top][left][c];
                for (int dv = 0; dv < 2; dv++) begin
                    for (int dh = 0; dh < 2; dh++) begin
                        if (frame_score[top + dv][left + dh][c] > pooled) begin
                            pooled = frame_score[top + dv][left + dh][c];
                        end
                    end
                end
                merged[c] = frame_score[v][h][c] + pooled;
            end
            exp_label[v][h] = pick_label(merged[0], merged[1], merged[2], merged[3]);
        end
    end
endfunction

`endif

/* tb/seg_tb.sv */
`timescale 1ns/1ns

module seg_tb;

    import seg_pkg::*;

    typedef enum int {PAT_CONST, PAT_BLOCK, PAT_TIE, PAT_RANDOM} pattern_e;

    typedef struct packed {
        logic [7:0]     test;
        logic           last;
        logic [1:0]     label;
        logic [V_W-1:0] vcnt;
        logic [H_W-1:0] hcnt;
    } expect_t;

    localparam int NUM_TESTS    = 4;
    localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;
    localparam int SCORE_MIN    = -(1 << (SCORE_W - 1));
    localparam int SCORE_MAX    = (1 << (SCORE_W - 1)) - 1;

    // Test table with pattern, frame count and description
    pattern_e test_kind   [NUM_TESTS] = '{PAT_CONST, PAT_BLOCK, PAT_TIE, PAT_RANDOM};
    int       test_frames [NUM_TESTS] = '{4, 6, 3, 6};
    string    test_desc   [NUM_TESTS] = '{
        "constant frames, one leading class each",
        "single spike inside one 2x2 block",
        "equal merged scores and tie order",
        "random scores with extreme values"
    };

    logic           clock;
    logic           rst_n;
    score_vec_t     in_score;
    logic [V_W-1:0] in_vcnt;
    logic [H_W-1:0] in_hcnt;
    class_label_e   out_label;
    logic [V_W-1:0] out_vcnt;
    logic [H_W-1:0] out_hcnt;
    logic           out_valid;

    logic [15:0] lfsr_state;
    int          frame_score [FRAME_HEIGHT][FRAME_WIDTH][NUM_CLASSES];
    int          exp_label [FRAME_HEIGHT][FRAME_WIDTH];
    expect_t     exp_q [$];
    int          test_errors [NUM_TESTS];
    int          errors;
    int          sent;
    int          checked;
    int          passed;
    int          rv;
    int          rh;
    int          cycles;
    int          timeout_limit;

    `include "seg_model.svh"

    seg_top DUT (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_score  (in_score),
        .in_vcnt   (in_vcnt),
        .in_hcnt   (in_hcnt),
        .out_label (out_label),
        .out_vcnt  (out_vcnt),
        .out_hcnt  (out_hcnt),
        .out_valid (out_valid)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        if (rst_n) begin
            cycles <= cycles + 1;
            if (cycles > timeout_limit) begin
                $display("Timeout: run still busy after %0d cycles", timeout_limit);
                $display("TEST FAILED");
                $finish;
            end
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    task automatic fill_frame(input pattern_e kind, input int f);
        int bk;
        int bj;
        int dv;
        int dh;
        int ch;
        int sel;
        int raw;
        bk = 0;
        bj = 0;
        dv = 0;
        dh = 0;
        ch = 1;
        if (kind == PAT_BLOCK) begin
            bk = take_bits(2);
            bj = take_bits(3);
            dv = take_bits(1);
            dh = take_bits(1);
            ch = 1 + take_bits(2) % 3;
        end
        for (int v = 0; v < FRAME_HEIGHT; v++) begin
            for (int h = 0; h < FRAME_WIDTH; h++) begin
                for (int c = 0; c < NUM_CLASSES; c++) begin
                    case (kind)
                        PAT_CONST: begin
                            frame_score[v][h][c] = (c == f % NUM_CLASSES) ?
                                                   1000 : 10 * c - 500;
                        end
                        PAT_BLOCK: begin
                            frame_score[v][h][c] = (c == 0) ? 100 : 0;
                            if (v == 2 * bk + dv && h == 2 * bj + dh && c == ch) begin
                                frame_score[v][h][c] = 2000;
                            end
                        end
                        // 0 and 1 tied, all four tied, then both pair maxima tied
                        PAT_TIE: frame_score[v][h][c] = (f % 3 == 0) ? ((c < 2) ? 500 : -100) :
                                                        (f % 3 == 1) ? 300 : ((c % 2 == 0) ? 400 : 0);
                        default: begin
                            sel = take_bits(3);
                            raw = take_bits(SCORE_W);
                            frame_score[v][h][c] = (sel == 0) ? SCORE_MIN :
                                                   (sel == 1) ? SCORE_MAX :
                                                   ((raw > SCORE_MAX) ? raw - (1 << SCORE_W) : raw);
                        end
                    endcase
                end
            end
        end
    endtask

    // Raster counter keeps running through flush pixels
    task automatic drive_pixel(input int test, input bit last, input bit real_pix);
        for (int c = 0; c < NUM_CLASSES; c++) begin
            if (real_pix) begin
                in_score[c] = score_t'(frame_score[rv][rh][c]);
            end else begin
                in_score[c] = '0;
            end
        end
        in_vcnt = rv[V_W-1:0];
        in_hcnt = rh[H_W-1:0];
        if (real_pix) begin
            exp_q.push_back('{test[7:0], last, exp_label[rv][rh][1:0],
                              rv[V_W-1:0], rh[H_W-1:0]});
        end
        sent++;
        if (rh == FRAME_WIDTH - 1) begin
            rh = 0;
            rv = (rv == FRAME_HEIGHT - 1) ? 0 : rv + 1;
        end else begin
            rh++;
        end
    endtask

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    task automatic check_outputs();
        expect_t e;
        int      idx;
        if (sent < PIPE_LATENCY) begin
            if (out_valid !== 1'b0) begin
                $display("Error %0t ns: out_valid high %0d cycles after reset", $time, sent);
                errors++;
                test_errors[0]++;
            end
        end else if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            idx = int'(e.test);
            checked++;
            if (out_valid !== 1'b1 || out_label !== class_label_e'(e.label) ||
                out_vcnt !== e.vcnt || out_hcnt !== e.hcnt) begin
                $display(
                    "Error %0t ns: pixel (%0d,%0d) valid %b label %0d at (%0d,%0d), expected %0d",
                    $time, e.vcnt, e.hcnt, out_valid, out_label, out_vcnt, out_hcnt, e.label);
                errors++;
                test_errors[idx]++;
            end
            if (e.last) begin
                $display("Test %0d, %s: %0d frames, %0d errors", idx, test_desc[idx],
                         test_frames[idx], test_errors[idx]);
            end
        end
    endtask

    initial begin
        rst_n = 1'b0;
        in_score = '0;
        in_vcnt = '0;
        in_hcnt = '0;
        lfsr_state = 16'd53;
        errors = 0;
        sent = 0;
        checked = 0;
        passed = 0;
        rv = 0;
        rh = 0;
        cycles = 0;
        timeout_limit = PIPE_LATENCY + 100;
        for (int t = 0; t < NUM_TESTS; t++) begin
            timeout_limit += test_frames[t] * FRAME_PIXELS;
            test_errors[t] = 0;
        end
        repeat (10) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int f = 0; f < test_frames[t]; f++) begin
                fill_frame(test_kind[t], f);
                predict_frame();
                for (int p = 0; p < FRAME_PIXELS; p++) begin
                    check_outputs();
                    drive_pixel(t, (f == test_frames[t] - 1) && (p == FRAME_PIXELS - 1), 1'b1);
                    @(negedge clock);
                end
            end
        end
        // Zero pixels push the last frame out of the pipeline
        while (exp_q.size() > 0) begin
            check_outputs();
            drive_pixel(0, 1'b0, 1'b0);
            @(negedge clock);
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            passed += (test_errors[t] == 0) ? 1 : 0;
        end
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d pixels checked, %0d errors",
                 NUM_TESTS, passed, NUM_TESTS - passed, checked, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+tb
source/seg_pkg.sv
source/max_pool.sv
source/skip_line_delay.sv
source/unpool_merge.sv
source/class_argmax.sv
source/seg_top.sv
tb/seg_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and scan the log for the fail message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f compile.f --top-module seg_tb -o seg_sim &&
./obj_dir/seg_sim > sim.log 2>&1 &&
cat sim.log &&
! grep -q "TEST FAILED" sim.log && grep -q "TEST PASSED" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed, see sim.log"; exit 1; }
